//--- logic/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Cache geometry
`define ICACHE_LINES 32
`define ICACHE_ASSOC 2
`define ICACHE_LINE_LOG 7

// Sets per way, lines split evenly over the ways
`define ICACHE_SETS (`ICACHE_LINES / `ICACHE_ASSOC)

// Data array organisation
`define ICACHE_ROWS_PER_LINE 8
`define ICACHE_WORDS_PER_ROW 4

`endif

//--- logic/icachePkg.sv
`default_nettype none
`include "icache_params.svh"

package icachePkg;

    typedef logic [31:0] pc_t;
    typedef logic [31-`ICACHE_LINE_LOG-$clog2(`ICACHE_SETS):0] tag_t; // Above set index
    typedef logic [$clog2(`ICACHE_SETS)-1:0] setIdx_t;
    typedef logic [$clog2(`ICACHE_ASSOC)-1:0] way_t;

    // Way, set, row within line
    typedef logic [$clog2(`ICACHE_LINES*`ICACHE_ROWS_PER_LINE)-1:0] sramRow_t;

    typedef logic [29:0] extAddr_t; // Word address
    typedef logic [31:0] word_t;
    typedef logic [32*`ICACHE_WORDS_PER_ROW-1:0] fetchBlock_t;

    typedef enum logic {
        MEMC_NONE,
        MEMC_CP_EXT_TO_CACHE
    } memcCmd_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_RQ,
        LOAD_ACTIVE,
        FLUSH_WAIT
    } tableState_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_RELEASE,
        FILL_WRITE
    } fillState_t;

endpackage

`default_nettype wire

//--- logic/memcIf.sv
`default_nettype none

// Fill command link from the tag table to the line filler.
// Fields stay stable from cmd set until busy is seen high.
interface memcIf;

    icachePkg::memcCmd_t cmd;
    icachePkg::sramRow_t sramBase; // First data array row of the line
    icachePkg::extAddr_t extBase;  // First external word of the line
    logic                busy;     // High while a line is being copied

    modport tagTable (
        output cmd,
        output sramBase,
        output extBase,
        input  busy
    );

    modport filler (
        input  cmd,
        input  sramBase,
        input  extBase,
        output busy
    );

endinterface

`default_nettype wire

//--- logic/icacheData.sv
`default_nettype none
`include "icache_params.svh"

module icacheData (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           wrEn,
    input  wire icachePkg::sramRow_t      wrRow,
    input  wire icachePkg::fetchBlock_t   wrData,
    input  wire                           rdEn,
    input  wire icachePkg::sramRow_t      rdRow,
    output icachePkg::fetchBlock_t        rdData,
    output logic                          rdValid
);

    // One row per 16 bytes of every line
    icachePkg::fetchBlock_t mem [`ICACHE_LINES * `ICACHE_ROWS_PER_LINE];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrRow] <= wrData;
        end
        if (rdEn) begin
            rdData <= mem[rdRow];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdEn; // Data one cycle after the request
        end
    end

endmodule

`default_nettype wire

//--- logic/icacheTable.sv
`default_nettype none
`include "icache_params.svh"

module icacheTable (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  fetchValid,
    input  wire icachePkg::pc_t  fetchPc,
    output logic                 fetchStall,
    output logic                 rdEn,
    output icachePkg::sramRow_t  rdRow,
    memcIf.tagTable              memc
);

    localparam int SET_BITS = $clog2(`ICACHE_SETS);
    localparam int ROW_SEL  = $clog2(`ICACHE_ROWS_PER_LINE);
    localparam int ROW_LOG  = $clog2(`ICACHE_WORDS_PER_ROW * 4); // Bytes per row

    icachePkg::tag_t        tags [`ICACHE_SETS][`ICACHE_ASSOC];
    logic                   valid [`ICACHE_SETS][`ICACHE_ASSOC];
    icachePkg::way_t        rrPtr [`ICACHE_SETS];
    icachePkg::tableState_t state;

    icachePkg::setIdx_t     setIdx;
    icachePkg::tag_t        lookupTag;
    icachePkg::way_t        hitWay;
    icachePkg::way_t        victim;
    logic                   hit;
    logic                   missStart;
    icachePkg::setIdx_t     loadSet;
    icachePkg::way_t        loadWay;

    always_comb begin
        setIdx    = icachePkg::setIdx_t'(fetchPc >> `ICACHE_LINE_LOG);
        lookupTag = icachePkg::tag_t'(fetchPc >> (`ICACHE_LINE_LOG + SET_BITS));
        hit       = 1'b0;
        hitWay    = '0;
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            if (valid[setIdx][w] && tags[setIdx][w] == lookupTag) begin
                hit    = 1'b1;
                hitWay = icachePkg::way_t'(w);
            end
        end
    end

    assign victim     = rrPtr[setIdx];
    assign fetchStall = fetchValid && (!hit || state != icachePkg::IDLE);
    assign rdEn       = fetchValid && !fetchStall;
    assign rdRow      = {hitWay, setIdx, fetchPc[`ICACHE_LINE_LOG-1:ROW_LOG]};
    assign missStart  = fetchValid && !hit && state == icachePkg::IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= icachePkg::FLUSH_WAIT;
            memc.cmd <= icachePkg::MEMC_NONE;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                rrPtr[s] <= '0;
                for (int w = 0; w < `ICACHE_ASSOC; w++) begin
                    valid[s][w] <= 1'b0;
                end
            end
        end else begin
            // Step past a way once it has been used
            if (rdEn && rrPtr[setIdx] == hitWay) begin
                rrPtr[setIdx] <= rrPtr[setIdx] + 1'b1;
            end

            case (state)
                icachePkg::FLUSH_WAIT: begin
                    if (!memc.busy) begin
                        state <= icachePkg::IDLE;
                    end
                end
                icachePkg::LOAD_RQ: begin
                    if (memc.busy) begin // Filler took the command
                        memc.cmd <= icachePkg::MEMC_NONE;
                        state    <= icachePkg::LOAD_ACTIVE;
                    end
                end
                icachePkg::LOAD_ACTIVE: begin
                    if (!memc.busy) begin // Whole line written
                        valid[loadSet][loadWay] <= 1'b1;
                        state                   <= icachePkg::IDLE;
                    end
                end
                default: begin
                    if (missStart) begin
                        memc.cmd              <= icachePkg::MEMC_CP_EXT_TO_CACHE;
                        valid[setIdx][victim] <= 1'b0;
                        state                 <= icachePkg::LOAD_RQ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (missStart) begin
            tags[setIdx][victim] <= lookupTag;
            loadSet              <= setIdx;
            loadWay              <= victim;
            memc.sramBase        <= {victim, setIdx, {ROW_SEL{1'b0}}};
            memc.extBase         <= {fetchPc[31:`ICACHE_LINE_LOG],
                                     {(`ICACHE_LINE_LOG-2){1'b0}}}; // Line start word
        end
    end

endmodule

`default_nettype wire

//--- logic/lineFiller.sv
`default_nettype none
`include "icache_params.svh"

module lineFiller (
    input  wire                     clk,
    input  wire                     rst,
    memcIf.filler                   memc,
    output logic                    extReq,
    output icachePkg::extAddr_t     extAddr,
    input  wire                     extAck,
    input  wire icachePkg::word_t   extData,
    output logic                    wrEn,
    output icachePkg::sramRow_t     wrRow,
    output icachePkg::fetchBlock_t  wrData
);

    localparam int WORD_BITS = `ICACHE_LINE_LOG - 2; // Words per line, log2
    localparam int WORD_SEL  = $clog2(`ICACHE_WORDS_PER_ROW);
    localparam int ROW_SEL   = $clog2(`ICACHE_ROWS_PER_LINE);
    localparam int EXT_BITS  = $bits(icachePkg::extAddr_t);
    localparam int SRAM_BITS = $bits(icachePkg::sramRow_t);
    localparam int WORD_W    = $bits(icachePkg::word_t);

    icachePkg::fillState_t         state;
    logic [WORD_BITS-1:0]          wordCnt;   // Word within line
    logic [EXT_BITS-WORD_BITS-1:0] extLine;
    logic [SRAM_BITS-ROW_SEL-1:0]  lineSel;
    icachePkg::fetchBlock_t        rowBuf;
    logic                          accept;
    logic                          lastInRow;

    assign accept    = state == icachePkg::FILL_IDLE &&
                       memc.cmd == icachePkg::MEMC_CP_EXT_TO_CACHE;
    assign lastInRow = &wordCnt[WORD_SEL-1:0];

    assign extAddr = {extLine, wordCnt}; // Only moves while extReq is low
    assign wrEn    = state == icachePkg::FILL_WRITE;
    assign wrRow   = {lineSel, wordCnt[WORD_BITS-1 -: ROW_SEL]};
    assign wrData  = rowBuf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= icachePkg::FILL_IDLE;
            memc.busy <= 1'b0;
            extReq    <= 1'b0;
            wordCnt   <= '0;
        end else begin
            case (state)
                icachePkg::FILL_IDLE: begin
                    if (accept) begin
                        memc.busy <= 1'b1;
                        extReq    <= 1'b1;
                        wordCnt   <= '0;
                        state     <= icachePkg::FILL_REQ;
                    end
                end
                icachePkg::FILL_REQ: begin
                    if (extAck) begin // Word captured below
                        extReq <= 1'b0;
                        state  <= icachePkg::FILL_RELEASE;
                    end
                end
                icachePkg::FILL_RELEASE: begin
                    if (!extAck) begin
                        if (lastInRow) begin
                            state <= icachePkg::FILL_WRITE;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                            extReq  <= 1'b1;
                            state   <= icachePkg::FILL_REQ;
                        end
                    end
                end
                default: begin
                    // Row goes out this cycle
                    if (&wordCnt) begin
                        memc.busy <= 1'b0;
                        state     <= icachePkg::FILL_IDLE;
                    end else begin
                        wordCnt <= wordCnt + 1'b1;
                        extReq  <= 1'b1;
                        state   <= icachePkg::FILL_REQ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            extLine <= memc.extBase[EXT_BITS-1:WORD_BITS];
            lineSel <= memc.sramBase[SRAM_BITS-1:ROW_SEL];
        end
        if (state == icachePkg::FILL_REQ && extAck) begin
            rowBuf[wordCnt[WORD_SEL-1:0]*WORD_W +: WORD_W] <= extData; // Low address low
        end
    end

endmodule

`default_nettype wire

//--- logic/icacheTop.sv
`default_nettype none

module icacheTop (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     fetchValid,
    input  wire icachePkg::pc_t     fetchPc,
    output logic                    fetchStall,
    output icachePkg::fetchBlock_t  fetchData,
    output logic                    fetchDataValid,
    output logic                    extReq,
    output icachePkg::extAddr_t     extAddr,
    input  wire                     extAck,
    input  wire icachePkg::word_t   extData
);

    memcIf memcBus ();

    logic                   rdEn;
    icachePkg::sramRow_t    rdRow;
    logic                   wrEn;
    icachePkg::sramRow_t    wrRow;
    icachePkg::fetchBlock_t wrData;

    icacheTable icacheTable_i (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchStall (fetchStall),
        .rdEn       (rdEn),
        .rdRow      (rdRow),
        .memc       (memcBus.tagTable)
    );

    lineFiller lineFiller_i (
        .clk     (clk),
        .rst     (rst),
        .memc    (memcBus.filler),
        .extReq  (extReq),
        .extAddr (extAddr),
        .extAck  (extAck),
        .extData (extData),
        .wrEn    (wrEn),
        .wrRow   (wrRow),
        .wrData  (wrData)
    );

    icacheData icacheData_i (
        .clk     (clk),
        .rst     (rst),
        .wrEn    (wrEn),
        .wrRow   (wrRow),
        .wrData  (wrData),
        .rdEn    (rdEn),
        .rdRow   (rdRow),
        .rdData  (fetchData),
        .rdValid (fetchDataValid)
    );

endmodule

`default_nettype wire

//--- testbench/icacheTop_properties.sv
`default_nettype none

module icacheTop_properties (
    input wire                      clk,
    input wire                      rst,
    input wire                      fetchValid,
    input wire                      fetchStall,
    input wire                      fetchDataValid,
    input wire                      extReq,
    input wire icachePkg::extAddr_t extAddr,
    input wire                      extAck
);

    int failCount = 0; // Failed assertions so far

    addrStable: assert property (@(posedge clk) disable iff (rst)
        extReq && $past(extReq) |-> $stable(extAddr))
        else begin
            failCount++;
            $error("extAddr changed while extReq was high");
        end

    // A new request only after the previous ack was released
    reqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(extReq) |-> !$past(extAck))
        else begin
            failCount++;
            $error("extReq rose while extAck was still high");
        end

    dataNeedsRequest: assert property (@(posedge clk) disable iff (rst)
        fetchDataValid |-> $past(fetchValid && !fetchStall))
        else begin
            failCount++;
            $error("fetchDataValid without an accepted fetch");
        end

    noIdleStall: assert property (@(posedge clk) disable iff (rst)
        !fetchValid |-> !fetchStall)
        else begin
            failCount++;
            $error("fetchStall high with fetchValid low");
        end

endmodule

bind icacheTop icacheTop_properties props_i (
    .clk            (clk),
    .rst            (rst),
    .fetchValid     (fetchValid),
    .fetchStall     (fetchStall),
    .fetchDataValid (fetchDataValid),
    .extReq         (extReq),
    .extAddr        (extAddr),
    .extAck         (extAck)
);

`default_nettype wire

//--- testbench/icacheTb.sv
`default_nettype none

module icacheTb;

    localparam int MISS_TIMEOUT = 1000; // Cycles for one line fill
    localparam int NUM_RANDOM   = 2000;

    logic                   clk;
    logic                   rst;
    logic                   fetchValid;
    icachePkg::pc_t         fetchPc;
    logic                   fetchStall;
    icachePkg::fetchBlock_t fetchData;
    logic                   fetchDataValid;
    logic                   extReq;
    icachePkg::extAddr_t    extAddr;
    logic                   extAck;
    icachePkg::word_t       extData;

    integer seed = 32'h6521_2f2a;
    int     readCount = 0;  // Words served by the responder
    int     modelReads = 0;
    int     modelHits = 0;
    int     dutHits = 0;
    int     ackDelay = 0;
    icachePkg::extAddr_t    expAddr;
    logic                   pendValid = 1'b0; // Expected fetchDataValid this cycle
    icachePkg::fetchBlock_t pendData;

    icachePkg::tag_t mTag [16][2];
    logic            mValid [16][2];
    icachePkg::way_t mRr [16];

    icacheTop icacheTop_i (
        .clk            (clk),
        .rst            (rst),
        .fetchValid     (fetchValid),
        .fetchPc        (fetchPc),
        .fetchStall     (fetchStall),
        .fetchData      (fetchData),
        .fetchDataValid (fetchDataValid),
        .extReq         (extReq),
        .extAddr        (extAddr),
        .extAck         (extAck),
        .extData        (extData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(icacheTop_i.props_i.failCount) begin
        if (icacheTop_i.props_i.failCount != 0) begin
            $display("assertion failure in the bound properties");
            $display("Checks failed");
            $fatal(1, "stopping at first assertion failure");
        end
    end

    function automatic icachePkg::word_t memWord(input icachePkg::extAddr_t a);
        icachePkg::word_t x;
        int rot;
        x   = {2'b00, a} ^ 32'h5a3c_96e1;
        rot = a[4:0];
        return (x << rot) | (x >> (32 - rot));
    endfunction

    function automatic icachePkg::fetchBlock_t blockFor(input icachePkg::pc_t pc);
        icachePkg::fetchBlock_t blk;
        icachePkg::extAddr_t base;
        base = {pc[31:4], 2'b00};
        for (int i = 0; i < 4; i++) begin
            blk[i*32 +: 32] = memWord(base + i); // Lowest word in low bits
        end
        return blk;
    endfunction

    function automatic logic lookup(input int s, input icachePkg::tag_t t, output int way);
        logic hit;
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (mValid[s][w] && mTag[s][w] == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        return hit;
    endfunction

    task automatic checkVal(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic checkOutput();
        checkVal("fetchDataValid", pendValid, fetchDataValid);
        if (pendValid) begin
            checkVal("fetchData", pendData, fetchData);
        end
    endtask

    // Answers each word read after 0 to 3 cycles
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (extAck) begin
                if (!extReq) begin
                    extAck = 1'b0;
                end
            end else if (extReq) begin
                if (ackDelay == 0) begin
                    checkVal("extAddr", expAddr, extAddr);
                    expAddr   = expAddr + 1'b1;
                    extData   = memWord(extAddr);
                    extAck    = 1'b1;
                    readCount++;
                    ackDelay  = $unsigned($random(seed)) % 4;
                end else begin
                    ackDelay--;
                end
            end
        end
    end

    task automatic doIdle();
        fetchValid = 1'b0;
        fetchPc    = $random(seed);
        @(negedge clk);
        checkOutput();
        checkVal("fetchStall", 1'b0, fetchStall);
        @(posedge clk);
        #1;
        pendValid = 1'b0;
    endtask

    task automatic doFetch(input icachePkg::pc_t pc);
        int              way;
        int              waited;
        int              s;
        icachePkg::tag_t t;
        logic            hit;
        s          = pc[10:7];
        t          = pc[31:11];
        hit        = lookup(s, t, way);
        fetchValid = 1'b1;
        fetchPc    = pc;
        @(negedge clk);
        checkOutput();
        checkVal("fetchStall", !hit, fetchStall);
        if (!fetchStall) begin
            dutHits++;
        end
        if (!hit) begin
            way             = mRr[s]; // Round-robin victim
            mValid[s][way]  = 1'b0;
            expAddr         = {pc[31:7], 5'b0};
            modelReads     += 32;
            waited          = 0;
            while (fetchStall) begin
                @(posedge clk);
                #1;
                pendValid = 1'b0;
                @(negedge clk);
                waited++;
                if (waited > MISS_TIMEOUT) begin
                    $display("timeout: fetchStall stuck high during line fill");
                    $display("Checks failed");
                    $fatal(1, "line fill did not finish");
                end
                checkOutput();
            end
            mTag[s][way]   = t;
            mValid[s][way] = 1'b1;
        end
        checkVal("extReadCount", modelReads, readCount);
        @(posedge clk);
        #1;
        if (mRr[s] == way) begin
            mRr[s] = mRr[s] + 1'b1;
        end
        pendValid = 1'b1;
        pendData  = blockFor(pc);
        if (hit) begin
            modelHits++;
        end
    endtask

    function automatic icachePkg::pc_t makePc(input icachePkg::tag_t t, input logic [3:0] s,
                                              input logic [6:0] low);
        return {t, s, low};
    endfunction

    initial begin
        icachePkg::tag_t tagPool [4];
        logic [3:0]      setPool [2];
        int              r;
        tagPool    = '{21'h0_1a2b, 21'h1_0004, 21'h0_0777, 21'h1_f00d};
        setPool    = '{4'd3, 4'd9};
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchPc    = '0;
        extAck     = 1'b0;
        extData    = '0;
        for (int s = 0; s < 16; s++) begin
            mRr[s] = '0;
            for (int w = 0; w < 2; w++) begin
                mValid[s][w] = 1'b0;
                mTag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkVal("fetchStall", 1'b0, fetchStall);
        checkVal("fetchDataValid", 1'b0, fetchDataValid);
        checkVal("extReq", 1'b0, extReq);
        @(posedge clk);
        #1;

        // Three tags in set 5, then the kept one and the evicted one
        doFetch(makePc(21'h00011, 4'd5, 7'h10));
        doFetch(makePc(21'h00022, 4'd5, 7'h20));
        doFetch(makePc(21'h00033, 4'd5, 7'h30));
        doFetch(makePc(21'h00022, 4'd5, 7'h40));
        doFetch(makePc(21'h00011, 4'd5, 7'h50));
        doIdle();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            if (r[9:7] == 3'd0) begin
                doIdle();
            end
            doFetch(makePc(tagPool[r[1:0]], setPool[r[2]], $random(seed)));
        end
        doIdle();

        checkVal("hitCount", modelHits, dutHits);
        checkVal("extReadCount", modelReads, readCount);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/icachePkg.sv
logic/memcIf.sv
logic/icacheData.sv
logic/icacheTable.sv
logic/lineFiller.sv
logic/icacheTop.sv
testbench/icacheTop_properties.sv
testbench/icacheTb.sv
